// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_video_top
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

SRCS := $(wildcard *.sv) $(wildcard *.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
		echo "FAIL"; exit 1; \
	elif ! grep -q "All tests passed" $(LOG); then \
		echo "FAIL: no result in $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: color_lut.sv
`default_nettype none
`timescale 1ns/100ps

`include "video_params.svh"

module color_lut (
    input  logic                   clk,
    lut_wr_if.tbl                  wr_i,
    input  logic [`VID_IDX_W-1:0]  idx_a_i,
    input  logic [`VID_IDX_W-1:0]  idx_b_i,
    output video_color_pkg::argb_t argb_a_o,
    output video_color_pkg::argb_t argb_b_o
);
    // bank 0 serves playfield A, bank 1 playfield B
    video_color_pkg::argb_t mem [2][`VID_LUT_DEPTH];
    logic [`VID_IDX_W-1:0]  rd_idx [2];
    video_color_pkg::argb_t rd_q   [2];

    assign rd_idx[0] = idx_a_i;
    assign rd_idx[1] = idx_b_i;

    always_ff @(posedge clk) begin
        for (int bank = 0; bank < 2; bank++) begin
            // nonblocking, so a same-cycle read still sees the old word
            if (wr_i.we && (wr_i.bank == bank[0])) begin
                mem[bank][wr_i.addr] <= wr_i.data;
            end
            rd_q[bank] <= mem[bank][rd_idx[bank]];  // one clock read latency
        end
    end

    assign argb_a_o = rd_q[0];
    assign argb_b_o = rd_q[1];

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
video_color_pkg.sv
video_timing_pkg.sv
video_if.sv
video_timing.sv
color_lut.sv
video_blend.sv
video_top.sv
video_asserts.sv
tb_clock_gen.sv
tb_video_top.sv

// File: tb_clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

// free-running pixel clock for the testbench
module tb_clock_gen (
    output logic clk_o
);
    localparam time HALF_PERIOD = 20ns;     // 40 ns period

    initial clk_o = 1'b0;

    always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: tb_video_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "video_params.svh"

module tb_video_top;
    localparam int H_ACTIVE = `VID_H_ACTIVE;
    localparam int H_SYNC   = `VID_H_SYNC;
    localparam int H_TOTAL  = `VID_H_TOTAL;
    localparam int V_ACTIVE = `VID_V_ACTIVE;
    localparam int V_SYNC   = `VID_V_SYNC;
    localparam int V_TOTAL  = `VID_V_TOTAL;
    localparam int FRAME    = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT  = 4 * FRAME;       // cycles allowed per wait loop

    // how the alpha nibbles of a table fill are constrained
    localparam int FILL_OPAQUE = 0;     // A only, or alpha with weight 0/3
    localparam int FILL_FRAC   = 1;     // alpha with weight 1/2
    localparam int FILL_ADD    = 2;     // wrap or clamp
    localparam int FILL_ANY    = 3;

    logic                  clk;
    logic                  rst_n;
    logic                  lut_we;
    logic                  lut_bank;
    logic [`VID_IDX_W-1:0] lut_addr;
    logic [15:0]           lut_data;
    logic [`VID_IDX_W-1:0] idx_a;
    logic [`VID_IDX_W-1:0] idx_b;
    logic [11:0]           rgb;
    logic                  hsync;
    logic                  vsync;
    logic                  de;

    logic [15:0] bank_copy [2][`VID_LUT_DEPTH];    // software image of both banks
    logic [31:0] lfsr;
    logic [11:0] exp_hist [2];      // expected pixel per driven index pair, [0] newest
    logic        hist_ok [2];       // table image was known when the pair was driven
    logic        model_ready;
    int          pix_checked;

    tb_clock_gen u_clk_gen (
        .clk_o (clk)
    );

    video_top u_video_top (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .lut_we_i   (lut_we),
        .lut_bank_i (lut_bank),
        .lut_addr_i (lut_addr),
        .lut_data_i (lut_data),
        .pf_a_idx_i (idx_a),
        .pf_b_idx_i (idx_b),
        .rgb_o      (rgb),
        .hsync_o    (hsync),
        .vsync_o    (vsync),
        .de_o       (de)
    );

    // x^32 + x^22 + x^2 + x + 1, one shift per bit handed out
    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    // one channel, a is the bottom layer
    function automatic logic [3:0] exp_chan(input int a, input int b,
                                            input logic [1:0] mode, input logic [1:0] wt);
        int r;
        case (mode)
            2'b00: begin                    // b weighted over a
                case (wt)
                    2'd0:    r = a;
                    2'd1:    r = (3 * a + b) / 4;
                    2'd2:    r = (a + b) / 2;
                    default: r = b;
                endcase
            end
            2'b01:   r = (a + b) % 16;
            2'b10:   r = (a >= 8 && b >= 8) ? 15 : (a + b) % 16;
            default: r = a;
        endcase
        return r[3:0];
    endfunction

    // mode from A's top bits, weight from B's top bits
    function automatic logic [11:0] exp_pixel(input logic [15:0] a, input logic [15:0] b);
        logic [11:0] p;
        for (int c = 0; c < 3; c++) begin
            p[c*4 +: 4] = exp_chan(int'(a[c*4 +: 4]), int'(b[c*4 +: 4]), a[15:14], b[15:14]);
        end
        return p;
    endfunction

    function automatic logic [15:0] make_entry(input logic bank, input int kind);
        logic [15:0] w;
        logic [1:0]  top;
        w   = take_bits(16);
        top = w[15:14];
        case (kind)
            FILL_OPAQUE: top = {2{top[0]}};                         // 00 or 11 on both banks
            FILL_FRAC:   top = bank ? {top[0], ~top[0]} : 2'b00;
            FILL_ADD:    top = bank ? top : {top[0], ~top[0]};      // A picks wrap or clamp
            default:     ;
        endcase
        w[15:14] = top;
        return w;
    endfunction

    task automatic report_failure();
        $display("Some tests failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("[ERROR] %0t %s is %0d, expected %0d", $time, what, got, exp);
            report_failure();
        end
    endtask

    task automatic check_idle(input string when_s);
        assert (!hsync && !vsync && !de && rgb == 12'h000) else begin
            $display("[ERROR] %0t outputs not idle %s: hs=%b vs=%b de=%b rgb=%h",
                     $time, when_s, hsync, vsync, de, rgb);
            report_failure();
        end
    endtask

    // one pixel clock, check the outputs and then drive the next pair
    task automatic step(input logic [`VID_IDX_W-1:0] a, input logic [`VID_IDX_W-1:0] b);
        @(negedge clk);
        if (!de) begin
            assert (rgb == 12'h000) else begin
                $display("[ERROR] %0t rgb_o is %h in blanking", $time, rgb);
                report_failure();
            end
        end else if (hist_ok[1]) begin      // pair driven two clocks back
            assert (rgb == exp_hist[1]) else begin
                $display("[ERROR] %0t rgb_o is %h, expected %h", $time, rgb, exp_hist[1]);
                report_failure();
            end
            pix_checked++;
        end
        idx_a       = a;
        idx_b       = b;
        exp_hist[1] = exp_hist[0];
        hist_ok[1]  = hist_ok[0];
        exp_hist[0] = exp_pixel(bank_copy[0][a], bank_copy[1][b]);  // table as read this edge
        hist_ok[0]  = model_ready;
    endtask

    task automatic rand_step();
        logic [15:0] ra;
        logic [15:0] rb;
        ra = take_bits(`VID_IDX_W);
        rb = take_bits(`VID_IDX_W);
        step(ra[`VID_IDX_W-1:0], rb[`VID_IDX_W-1:0]);
    endtask

    // the write lands on the next rising edge, after the read of this cycle
    task automatic write_entry(input logic bank, input logic [`VID_IDX_W-1:0] addr,
                               input logic [15:0] data);
        rand_step();
        lut_we                = 1'b1;
        lut_bank              = bank;
        lut_addr              = addr;
        lut_data              = data;
        bank_copy[bank][addr] = data;
    endtask

    task automatic fill_tables(input int kind);
        logic [15:0] w;
        for (int bank = 0; bank < 2; bank++) begin
            for (int addr = 0; addr < `VID_LUT_DEPTH; addr++) begin
                w = make_entry(bank[0], kind);
                write_entry(bank[0], addr[`VID_IDX_W-1:0], w);
            end
        end
        rand_step();
        lut_we      = 1'b0;
        model_ready = 1'b1;
    endtask

    task automatic run_pixels(input int n);
        int start;
        int cycles;
        start  = pix_checked;
        cycles = 0;
        while (pix_checked - start < n) begin
            rand_step();
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: only %0d of %0d pixels were checked", pix_checked - start, n);
                report_failure();
            end
        end
    endtask

    // returns on the first clock with vsync_o low again
    task automatic wait_vsync_fall();
        logic prev;
        int   cycles;
        cycles = 0;
        prev   = vsync;
        rand_step();
        while (!(prev && !vsync)) begin
            prev = vsync;
            rand_step();
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: vsync_o never fell");
                report_failure();
            end
        end
    endtask

    task automatic test_reset();
        repeat (8) begin
            @(negedge clk);
            check_idle("during reset");
        end
        rst_n = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check_idle("after reset");
        end
    endtask

    task automatic test_raster();
        int   de_run;
        int   hs_run;
        int   vs_run;
        int   lines;
        int   pulses;
        int   cycles;
        logic de_p;
        logic hs_p;
        logic vs_p;
        wait_vsync_fall();
        de_run = 0;
        hs_run = 0;
        vs_run = 0;
        lines  = 0;
        pulses = 0;
        cycles = 0;
        vs_p   = 1'b0;
        de_p   = de;
        hs_p   = hsync;
        do begin
            if (de) begin
                de_run++;
            end else if (de_p) begin
                check_count("de_o run", de_run, H_ACTIVE);
                lines++;
                de_run = 0;
            end
            if (hsync) begin
                hs_run++;
            end else if (hs_p) begin
                check_count("hsync_o pulse width", hs_run, H_SYNC);
                pulses++;
                hs_run = 0;
            end
            if (vsync) vs_run++;
            de_p = de;
            hs_p = hsync;
            vs_p = vsync;
            rand_step();
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timeout: frame did not end with a vsync_o pulse");
                report_failure();
            end
        end while (!(vs_p && !vsync));
        check_count("frame length", cycles, FRAME);
        check_count("active lines", lines, V_ACTIVE);
        check_count("hsync_o pulses", pulses, V_TOTAL);
        check_count("vsync_o width", vs_run, V_SYNC * H_TOTAL);
    endtask

    task automatic test_opaque();
        fill_tables(FILL_OPAQUE);
        run_pixels(128);
    endtask

    task automatic test_fractional();
        fill_tables(FILL_FRAC);
        run_pixels(128);
    endtask

    task automatic test_additive();
        fill_tables(FILL_ADD);
        run_pixels(128);
    endtask

    task automatic test_random_frame();
        int start;
        fill_tables(FILL_ANY);
        wait_vsync_fall();
        start = pix_checked;
        repeat (FRAME) rand_step();
        check_count("pixels in one frame", pix_checked - start, H_ACTIVE * V_ACTIVE);
    endtask

    initial begin
        rst_n       = 1'b0;
        lut_we      = 1'b0;
        lut_bank    = 1'b0;
        lut_addr    = '0;
        lut_data    = '0;
        idx_a       = '0;
        idx_b       = '0;
        lfsr        = 32'hbc29;
        model_ready = 1'b0;
        pix_checked = 0;
        hist_ok[0]  = 1'b0;
        hist_ok[1]  = 1'b0;
        exp_hist[0] = '0;
        exp_hist[1] = '0;

        test_reset();
        test_raster();
        test_opaque();
        test_fractional();
        test_additive();
        test_random_frame();

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: video_asserts.sv
`default_nettype none
`timescale 1ns/100ps

`include "video_params.svh"

// output timing rules of video_top
module video_asserts (
    input logic                          clk,
    input logic                          rst_n_i,
    input logic                          hsync_i,
    input logic                          vsync_i,
    input logic                          de_i,
    input logic [11:0]                   rgb_i,
    input video_timing_pkg::line_phase_e phase_i,     // generator state, three clocks ahead
    input video_timing_pkg::h_count_t    h_count_i
);
    // hsync sits in horizontal blanking
    a_no_de_in_hsync: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(de_i && hsync_i))
        else $error("de_o and hsync_o are high together");

    a_black_in_blank: assert property (@(posedge clk) disable iff (!rst_n_i)
        !de_i |-> (rgb_i == 12'h000))
        else $error("rgb_o is not black while de_o is low");

    // vsync edges fall on line boundaries, away from the hsync pulse
    a_vsync_edge: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$stable(vsync_i) |-> !hsync_i)
        else $error("vsync_o changed while hsync_o was high");

    // phase register and counter walk the line together
    a_phase_count: assert property (@(posedge clk) disable iff (!rst_n_i)
        (phase_i == video_timing_pkg::PHASE_ACTIVE) == (h_count_i < `VID_H_ACTIVE))
        else $error("line phase and horizontal count disagree");

    // level register, sync delay, output register
    a_hsync_phase: assert property (@(posedge clk) disable iff (!rst_n_i)
        hsync_i == $past(phase_i == video_timing_pkg::PHASE_SYNC, 3))
        else $error("hsync_o is not three clocks behind the sync phase");

endmodule

bind video_top video_asserts u_video_asserts (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .hsync_i   (hsync_o),
    .vsync_i   (vsync_o),
    .de_i      (de_o),
    .rgb_i     (rgb_o),
    .phase_i   (u_tim_if.phase),
    .h_count_i (u_tim_if.h_count)
);

`default_nettype wire

// File: video_blend.sv
`default_nettype none
`timescale 1ns/100ps

module video_blend (
    input  logic                   clk,
    input  logic                   rst_n_i,
    video_timing_if.sink           tim_i,
    input  video_color_pkg::argb_t color_a_i,
    input  video_color_pkg::argb_t color_b_i,
    output video_color_pkg::rgb_t  rgb_o,
    output logic                   hsync_o,
    output logic                   vsync_o,
    output logic                   de_o
);
    // one channel of the blend, a is the bottom layer and b sits over it
    function automatic logic [3:0] blend_chan(
        input logic [3:0]                   a,
        input logic [3:0]                   b,
        input video_color_pkg::blend_mode_e mode,
        input logic [1:0]                   weight
    );
        logic [5:0] sum_75;     // 3a + b
        logic [4:0] sum_ab;     // a + b with carry
        logic [3:0] res;
        sum_75 = {2'b00, a} + {1'b0, a, 1'b0} + {2'b00, b};
        sum_ab = {1'b0, a} + {1'b0, b};
        unique case (mode)
            video_color_pkg::BLEND_ALPHA: begin
                unique case (weight)
                    2'd0:    res = a;
                    2'd1:    res = sum_75[5:2];     // 75% a, 25% b
                    2'd2:    res = sum_ab[4:1];     // half and half
                    default: res = b;
                endcase
            end
            video_color_pkg::BLEND_WRAP:  res = sum_ab[3:0];
            // saturates only when both msbs are set and wraps on any other carry
            video_color_pkg::BLEND_CLAMP: res = (a[3] && b[3]) ? 4'hf : sum_ab[3:0];
            default:                      res = a;
        endcase
        return res;
    endfunction

    video_color_pkg::blend_mode_e mode;
    logic [1:0]                   weight;
    video_color_pkg::rgb_t        blend_rgb;
    logic                         hsync_1;      // syncs delayed to match table read
    logic                         vsync_1;
    logic                         de_1;

    assign mode   = color_a_i.alpha.m.mode;      // A's nibble is a mode
    assign weight = color_b_i.alpha.w.weight;    // B's nibble is a weight

    always_comb begin
        blend_rgb.r = blend_chan(color_a_i.rgb.r, color_b_i.rgb.r, mode, weight);
        blend_rgb.g = blend_chan(color_a_i.rgb.g, color_b_i.rgb.g, mode, weight);
        blend_rgb.b = blend_chan(color_a_i.rgb.b, color_b_i.rgb.b, mode, weight);
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            hsync_1 <= 1'b0;
            vsync_1 <= 1'b0;
            de_1    <= 1'b0;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            de_o    <= 1'b0;
            rgb_o   <= '0;
        end else begin
            // stage 1, table lookup in flight
            hsync_1 <= tim_i.hsync;
            vsync_1 <= tim_i.vsync;
            de_1    <= tim_i.de;
            // stage 2, pixel and syncs leave together
            hsync_o <= hsync_1;
            vsync_o <= vsync_1;
            de_o    <= de_1;
            rgb_o   <= de_1 ? blend_rgb : '0;       // black in blanking
        end
    end

endmodule

`default_nettype wire

// File: video_color_pkg.sv
`default_nettype none

package video_color_pkg;

    // 12-bit output pixel, 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // how playfield A asks for A and B to be combined
    typedef enum logic [1:0] {
        BLEND_ALPHA  = 2'b00,   // B weighted over A
        BLEND_WRAP   = 2'b01,   // sum, modulo 16
        BLEND_CLAMP  = 2'b10,   // sum, saturating
        BLEND_A_ONLY = 2'b11    // A on top, B ignored
    } blend_mode_e;

    typedef struct packed {
        blend_mode_e mode;      // top two bits of A's nibble
        logic [1:0]  rsvd;
    } alpha_mode_t;

    typedef struct packed {
        logic [1:0] weight;     // 0 = all A .. 3 = all B
        logic [1:0] rsvd;
    } alpha_weight_t;

    // same nibble, read as a mode on A and as a weight on B
    typedef union packed {
        alpha_mode_t   m;
        alpha_weight_t w;
    } alpha_u;

    // color table entry
    typedef struct packed {
        alpha_u alpha;
        rgb_t   rgb;
    } argb_t;

endpackage

`default_nettype wire

// File: video_if.sv
`default_nettype none
`timescale 1ns/100ps

`include "video_params.svh"

// raster timing from the generator to the pixel path
interface video_timing_if;
    logic                          hsync;
    logic                          vsync;
    logic                          de;
    video_timing_pkg::line_phase_e phase;      // one clock ahead of the levels
    video_timing_pkg::h_count_t    h_count;    // same cycle as phase

    modport source (
        output hsync, vsync, de, phase, h_count
    );

    modport sink (
        input hsync, vsync, de
    );
endinterface

// color table write port, one-cycle strobe
interface lut_wr_if;
    logic                   we;     // write on this rising edge
    logic                   bank;   // 0 = playfield A, 1 = playfield B
    logic [`VID_IDX_W-1:0]  addr;
    video_color_pkg::argb_t data;

    modport host (
        output we, bank, addr, data
    );

    // table side of the port
    modport tbl (
        input we, bank, addr, data
    );
endinterface

`default_nettype wire

// File: video_params.svh
`ifndef VIDEO_PARAMS_SVH
`define VIDEO_PARAMS_SVH

// horizontal geometry in pixel clocks
`define VID_H_ACTIVE 16
`define VID_H_FRONT 2
`define VID_H_SYNC 3
`define VID_H_BACK 3
`define VID_H_TOTAL (`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC + `VID_H_BACK)

// vertical geometry in lines
`define VID_V_ACTIVE 4
`define VID_V_FRONT 1
`define VID_V_SYNC 2
`define VID_V_BACK 1
`define VID_V_TOTAL (`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC + `VID_V_BACK)

// color table
`define VID_LUT_DEPTH 16
`define VID_IDX_W 4

`endif

// File: video_timing.sv
`default_nettype none
`timescale 1ns/100ps

`include "video_params.svh"

module video_timing (
    input  logic           clk,
    input  logic           rst_n_i,
    video_timing_if.source tim_o
);
    // last count of each line segment
    localparam video_timing_pkg::h_count_t H_ACT_END =
        video_timing_pkg::h_count_t'(`VID_H_ACTIVE - 1);
    localparam video_timing_pkg::h_count_t H_FRONT_END =
        video_timing_pkg::h_count_t'(`VID_H_ACTIVE + `VID_H_FRONT - 1);
    localparam video_timing_pkg::h_count_t H_SYNC_END =
        video_timing_pkg::h_count_t'(`VID_H_ACTIVE + `VID_H_FRONT + `VID_H_SYNC - 1);
    localparam video_timing_pkg::h_count_t H_LAST =
        video_timing_pkg::h_count_t'(`VID_H_TOTAL - 1);

    localparam video_timing_pkg::v_count_t V_ACT   = video_timing_pkg::v_count_t'(`VID_V_ACTIVE);
    localparam video_timing_pkg::v_count_t V_SYNC0 =
        video_timing_pkg::v_count_t'(`VID_V_ACTIVE + `VID_V_FRONT);
    localparam video_timing_pkg::v_count_t V_SYNC1 =
        video_timing_pkg::v_count_t'(`VID_V_ACTIVE + `VID_V_FRONT + `VID_V_SYNC);
    localparam video_timing_pkg::v_count_t V_LAST =
        video_timing_pkg::v_count_t'(`VID_V_TOTAL - 1);

    video_timing_pkg::h_count_t    h_cnt;
    video_timing_pkg::v_count_t    v_cnt;
    video_timing_pkg::line_phase_e phase;
    video_timing_pkg::line_phase_e phase_next;
    logic                          phase_last;     // h_cnt at end of current segment
    logic                          line_last;

    always_comb begin
        unique case (phase)
            video_timing_pkg::PHASE_ACTIVE: begin
                phase_last = (h_cnt == H_ACT_END);
                phase_next = video_timing_pkg::PHASE_FRONT;
            end
            video_timing_pkg::PHASE_FRONT: begin
                phase_last = (h_cnt == H_FRONT_END);
                phase_next = video_timing_pkg::PHASE_SYNC;
            end
            video_timing_pkg::PHASE_SYNC: begin
                phase_last = (h_cnt == H_SYNC_END);
                phase_next = video_timing_pkg::PHASE_BACK;
            end
            default: begin                              // back porch closes the line
                phase_last = (h_cnt == H_LAST);
                phase_next = video_timing_pkg::PHASE_ACTIVE;
            end
        endcase
    end

    assign line_last = phase_last && (phase == video_timing_pkg::PHASE_BACK);

    // counters and phase, levels decoded from them one clock later
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            phase       <= video_timing_pkg::PHASE_ACTIVE;
            tim_o.hsync <= 1'b0;
            tim_o.vsync <= 1'b0;
            tim_o.de    <= 1'b0;
        end else begin
            h_cnt <= line_last ? '0 : h_cnt + 1'b1;
            if (phase_last) phase <= phase_next;
            if (line_last) v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;

            tim_o.de    <= (phase == video_timing_pkg::PHASE_ACTIVE) && (v_cnt < V_ACT);
            tim_o.hsync <= (phase == video_timing_pkg::PHASE_SYNC);
            tim_o.vsync <= (v_cnt >= V_SYNC0) && (v_cnt < V_SYNC1);  // whole lines
        end
    end

    assign tim_o.phase   = phase;
    assign tim_o.h_count = h_cnt;

endmodule

`default_nettype wire

// File: video_timing_pkg.sv
`default_nettype none

package video_timing_pkg;

    // wide enough for the line and frame totals
    typedef logic [7:0] h_count_t;
    typedef logic [5:0] v_count_t;

    // segments of one scan line, in order
    typedef enum logic [1:0] {
        PHASE_ACTIVE = 2'd0,    // visible pixels
        PHASE_FRONT  = 2'd1,    // front porch
        PHASE_SYNC   = 2'd2,    // hsync pulse
        PHASE_BACK   = 2'd3     // back porch
    } line_phase_e;

endpackage

`default_nettype wire

// File: video_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "video_params.svh"

module video_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    // color table write port
    input  logic                  lut_we_i,
    input  logic                  lut_bank_i,
    input  logic [`VID_IDX_W-1:0] lut_addr_i,
    input  logic [15:0]           lut_data_i,
    // playfield indices, one per pixel clock
    input  logic [`VID_IDX_W-1:0] pf_a_idx_i,
    input  logic [`VID_IDX_W-1:0] pf_b_idx_i,
    // pixel out, two clocks behind the indices
    output logic [11:0]           rgb_o,
    output logic                  hsync_o,
    output logic                  vsync_o,
    output logic                  de_o
);
    video_timing_if u_tim_if ();
    lut_wr_if       u_wr_if ();

    video_color_pkg::argb_t argb_a;     // table read data, one clock after index
    video_color_pkg::argb_t argb_b;
    video_color_pkg::rgb_t  pix;

    // host side of the write port comes straight from the pins
    assign u_wr_if.we   = lut_we_i;
    assign u_wr_if.bank = lut_bank_i;
    assign u_wr_if.addr = lut_addr_i;
    assign u_wr_if.data = lut_data_i;

    video_timing u_timing (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .tim_o   (u_tim_if.source)
    );

    color_lut u_lut (
        .clk      (clk),
        .wr_i     (u_wr_if.tbl),
        .idx_a_i  (pf_a_idx_i),
        .idx_b_i  (pf_b_idx_i),
        .argb_a_o (argb_a),
        .argb_b_o (argb_b)
    );

    video_blend u_blend (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .tim_i     (u_tim_if.sink),
        .color_a_i (argb_a),
        .color_b_i (argb_b),
        .rgb_o     (pix),
        .hsync_o   (hsync_o),
        .vsync_o   (vsync_o),
        .de_o      (de_o)
    );

    assign rgb_o = pix;     // r in [11:8], b in [3:0]

endmodule

`default_nettype wire
